// File: design/ospfb_macros.svh
`ifndef OSPFB_MACROS_SVH
`define OSPFB_MACROS_SVH

// sample word width, unsigned counter values
`define SAMP_W 16

// number of polyphase branches, one per channel
`define FFT_LEN 8

// new samples per frame, 8/6 gives 4/3 oversampling
`define DEC_FAC 6

// taps per branch
`define PFB_TAPS 3

// cdc fifo entries, power of two
`define FIFO_DEPTH 16

// capture slots, also the credit count after reset
`define CAP_DEPTH 16

`endif

// File: design/ospfb_pkg.sv
`include "ospfb_macros.svh"

package ospfb_pkg;

  typedef logic [`SAMP_W-1:0] sample_t;                     // raw counter sample
  typedef logic signed [7:0] coeff_t;                       // filter tap
  typedef logic signed [31:0] acc_t;                        // mac result and output word
  typedef logic [$clog2(`FFT_LEN)-1:0] branch_t;            // channel / branch index
  typedef logic [$clog2(`FIFO_DEPTH):0] level_t;            // fifo fill, 0..depth
  typedef logic [$clog2(`CAP_DEPTH):0] credit_t;            // 0..CAP_DEPTH credits
  typedef logic [$clog2(`PFB_TAPS*`FFT_LEN)-1:0] age_t;     // delay line age

  // channelizer sequencer
  typedef enum logic [1:0] {
    IDLE,         // taking samples from the fifo
    MAC,          // walking taps of one branch
    EMIT,         // result ready
    WAIT_CREDIT   // result ready, no capture slot yet
  } chan_state_t;

  // prototype filter, windowed sinc shape
  // symmetric about the middle of the 24 taps
  localparam coeff_t COEFF_TAB [24] = '{
    8'sd0,  -8'sd1, -8'sd2, -8'sd3, -8'sd3, -8'sd2,
    8'sd0,   8'sd4,  8'sd9,  8'sd15, 8'sd21, 8'sd25,
    8'sd25,  8'sd21, 8'sd15, 8'sd9,  8'sd4,  8'sd0,
    -8'sd2, -8'sd3, -8'sd3, -8'sd2, -8'sd1,  8'sd0
  };

  // tap lookup, idx = p*FFT_LEN + branch
  function automatic coeff_t coeff(input int unsigned idx);
    coeff_t c;
    c = '0;                           // out of range reads as zero
    if (idx < 24) begin
      c = COEFF_TAB[idx];
    end
    return c;
  endfunction

endpackage

// File: design/sample_counter.sv
`timescale 1ns/10ps
`include "ospfb_macros.svh"

module sample_counter (
  input  logic              clka,
  input  logic              rst_n,
  input  logic              en,
  input  logic              full,
  output ospfb_pkg::sample_t wr_data,
  output logic              wr_en
);

  import ospfb_pkg::*;

  sample_t count;  // next value to send

  // write whenever enabled and the fifo has room
  assign wr_en   = en && !full;
  assign wr_data = count;

  always_ff @(posedge clka) begin
    if (!rst_n) begin
      count <= '0;
    end else if (wr_en) begin
      count <= count + 1'b1;  // wraps at 2^SAMP_W
    end
  end

endmodule

// File: design/cdc_fifo.sv
`timescale 1ns/10ps
`include "ospfb_macros.svh"

module cdc_fifo (
  input  logic               clka,
  input  logic               clkb,
  input  logic               rst_n,
  input  ospfb_pkg::sample_t wr_data,
  input  logic               wr_en,
  output logic               full,
  output ospfb_pkg::sample_t rd_data,
  input  logic               rd_en,
  output logic               empty,
  output ospfb_pkg::level_t  rd_level
);

  import ospfb_pkg::*;

  localparam int AW = $clog2(`FIFO_DEPTH);  // address bits, pointers carry one more

  sample_t mem [`FIFO_DEPTH];

  logic [AW:0] wr_bin, wr_gray;   // clka side
  logic [AW:0] rq1_gray, rq2_gray; // read pointer synced into clka
  logic [AW:0] rd_bin, rd_gray;   // clkb side
  logic [AW:0] wq1_gray, wq2_gray; // write pointer synced into clkb
  logic [AW:0] wr_bin_nxt, rd_bin_nxt;
  logic        wr_fire, rd_fire;

  function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
    logic [AW:0] b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  assign wr_fire    = wr_en && !full;
  assign rd_fire    = rd_en && !empty;
  assign wr_bin_nxt = wr_bin + 1'b1;
  assign rd_bin_nxt = rd_bin + 1'b1;

  // write side, clka
  always_ff @(posedge clka) begin
    if (wr_fire) begin
      mem[wr_bin[AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst_n) begin
      wr_bin   <= '0;
      wr_gray  <= '0;
      rq1_gray <= '0;
      rq2_gray <= '0;
    end else begin
      if (wr_fire) begin
        wr_bin  <= wr_bin_nxt;
        wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
      end
      rq1_gray <= rd_gray;  // two flop sync
      rq2_gray <= rq1_gray;
    end
  end

  // full when pointers differ only in the top two gray bits
  assign full = (wr_gray == {~rq2_gray[AW:AW-1], rq2_gray[AW-2:0]});

  // read side, clkb
  always_ff @(posedge clkb) begin
    if (!rst_n) begin
      rd_bin   <= '0;
      rd_gray  <= '0;
      wq1_gray <= '0;
      wq2_gray <= '0;
    end else begin
      if (rd_fire) begin
        rd_bin  <= rd_bin_nxt;
        rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      end
      wq1_gray <= wr_gray;
      wq2_gray <= wq1_gray;
    end
  end

  assign empty    = (rd_gray == wq2_gray);
  assign rd_data  = mem[rd_bin[AW-1:0]];         // fwft, head word always on the port
  assign rd_level = gray2bin(wq2_gray) - rd_bin;  // lags writes by the sync delay

  a_no_overflow: assert property (
    @(posedge clka) disable iff (!rst_n) wr_en |-> !full
  );

  a_no_underflow: assert property (
    @(posedge clkb) disable iff (!rst_n) rd_en |-> !empty
  );

endmodule

// File: design/pfb_delay_line.sv
`timescale 1ns/10ps
`include "ospfb_macros.svh"

module pfb_delay_line (
  input  logic               clkb,
  input  logic               rst_n,
  input  logic               push,
  input  ospfb_pkg::sample_t push_data,
  input  ospfb_pkg::age_t    rd_age,
  output ospfb_pkg::sample_t rd_sample
);

  import ospfb_pkg::*;

  localparam int DEPTH = `PFB_TAPS * `FFT_LEN;  // full filter window
  localparam int PW    = $clog2(DEPTH);

  sample_t        mem [DEPTH];
  logic [PW-1:0]  wr_ptr;   // slot of the next push
  logic [PW-1:0]  rd_addr;

  // circular write, depth need not be a power of two
  always_ff @(posedge clkb) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clkb) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // age 0 is the newest sample, at wr_ptr - 1
  always_comb begin
    int unsigned raw;
    raw = int'(wr_ptr) + DEPTH - 1 - int'(rd_age);  // never negative
    if (raw >= DEPTH) begin
      raw = raw - DEPTH;
    end
    rd_addr = PW'(raw);
  end

  // registered read, data one cycle after the age
  always_ff @(posedge clkb) begin
    rd_sample <= mem[rd_addr];
  end

endmodule

// File: design/pfb_channelizer.sv
`timescale 1ns/10ps
`include "ospfb_macros.svh"

module pfb_channelizer (
  input  logic               clkb,
  input  logic               rst_n,
  input  logic               en,
  input  ospfb_pkg::sample_t rd_data,
  input  logic               empty,
  output logic               rd_en,
  output logic               push,
  output ospfb_pkg::sample_t push_data,
  output ospfb_pkg::age_t    rd_age,
  input  ospfb_pkg::sample_t rd_sample,
  input  logic               credit_ret,
  output logic               res_valid,
  output ospfb_pkg::acc_t    res_data,
  output ospfb_pkg::branch_t res_chan,
  output logic               res_last,
  output logic               event_frame_started
);

  import ospfb_pkg::*;

  localparam int WIN = `PFB_TAPS * `FFT_LEN;  // samples in the filter window
  localparam int TW  = $clog2(`PFB_TAPS + 1);
  localparam int FW  = $clog2(WIN + 1);
  localparam int DW  = $clog2(`DEC_FAC);

  chan_state_t    state;
  branch_t        pos;        // output position c within the frame
  branch_t        phase;      // m*DEC_FAC mod FFT_LEN
  branch_t        branch;     // (c + phase) mod FFT_LEN
  branch_t        phase_nxt;
  logic [TW-1:0]  tap;        // mac step, 0 primes the read
  logic [FW-1:0]  fill_cnt;   // samples so far, saturates at WIN
  logic [DW-1:0]  new_cnt;    // new samples since last frame
  credit_t        credits;
  acc_t           acc;
  acc_t           prod;
  logic           pop, frame_go, window_full;

  // take samples only between frames
  assign rd_en     = (state == IDLE) && en && !empty;
  assign pop       = rd_en;
  assign push      = pop;
  assign push_data = rd_data;

  assign window_full = (fill_cnt == FW'(WIN));
  // first frame on the WIN-th sample, then every DEC_FAC
  assign frame_go = pop && (window_full ? (new_cnt == DW'(`DEC_FAC - 1))
                                        : (fill_cnt == FW'(WIN - 1)));

  always_comb begin
    int unsigned bsum;
    int unsigned psum;
    int unsigned cidx;
    bsum = int'(pos) + int'(phase);
    if (bsum >= `FFT_LEN) bsum = bsum - `FFT_LEN;
    branch = branch_t'(bsum);
    psum = int'(phase) + (`DEC_FAC % `FFT_LEN);
    if (psum >= `FFT_LEN) psum = psum - `FFT_LEN;
    phase_nxt = branch_t'(psum);
    // age for tap p is p*FFT_LEN + branch, last step reads nothing useful
    rd_age = age_t'(((tap < TW'(`PFB_TAPS)) ? int'(tap) : 0) * `FFT_LEN + int'(branch));
    // data on rd_sample belongs to tap-1
    cidx = (tap == '0) ? 0 : (int'(tap) - 1) * `FFT_LEN + int'(branch);
    prod = acc_t'(signed'({1'b0, rd_sample})) * acc_t'(coeff(cidx));
  end

  // result handshake, credit gates the write
  assign res_valid = ((state == EMIT) || (state == WAIT_CREDIT)) && (credits != '0);
  assign res_data  = acc;
  assign res_chan  = pos;
  assign res_last  = (pos == branch_t'(`FFT_LEN - 1));

  always_ff @(posedge clkb) begin
    if (!rst_n) begin
      state               <= IDLE;
      pos                 <= '0;
      tap                 <= '0;
      phase               <= '0;
      fill_cnt            <= '0;
      new_cnt             <= '0;
      event_frame_started <= 1'b0;
    end else begin
      event_frame_started <= frame_go;  // lands on the first MAC cycle
      case (state)
        IDLE: begin
          if (pop && !window_full) fill_cnt <= fill_cnt + 1'b1;
          if (frame_go) begin
            new_cnt <= '0;
            pos     <= '0;
            tap     <= '0;
            state   <= MAC;
          end else if (pop && window_full) begin
            new_cnt <= new_cnt + 1'b1;
          end
        end
        MAC: begin
          if (tap == TW'(`PFB_TAPS)) begin
            tap   <= '0;
            state <= EMIT;
          end else begin
            tap <= tap + 1'b1;
          end
        end
        EMIT, WAIT_CREDIT: begin
          if (!res_valid) begin
            state <= WAIT_CREDIT;  // hold acc until a slot frees
          end else if (res_last) begin
            phase <= phase_nxt;    // rotation for the next frame
            state <= IDLE;
          end else begin
            pos   <= pos + 1'b1;
            state <= MAC;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clkb) begin
    if (state == MAC) acc <= (tap == '0) ? '0 : acc + prod;  // clear then sum taps
  end

  // one credit out per result, one back per capture pop
  always_ff @(posedge clkb) begin
    if (!rst_n) begin
      credits <= credit_t'(`CAP_DEPTH);
    end else begin
      case ({res_valid, credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  a_credit_bound: assert property (
    @(posedge clkb) disable iff (!rst_n) credits <= credit_t'(`CAP_DEPTH)
  );

endmodule

// File: design/frame_capture.sv
`timescale 1ns/10ps
`include "ospfb_macros.svh"

module frame_capture (
  input  logic               clkb,
  input  logic               rst_n,
  input  logic               res_valid,
  input  ospfb_pkg::acc_t    res_data,
  input  ospfb_pkg::branch_t res_chan,
  input  logic               res_last,
  output logic               out_valid,
  output ospfb_pkg::acc_t    out_data,
  output ospfb_pkg::branch_t out_chan,
  output logic               out_last,
  input  logic               out_ready,
  output logic               credit_ret
);

  import ospfb_pkg::*;

  localparam int AW = $clog2(`CAP_DEPTH);

  acc_t          data_mem [`CAP_DEPTH];
  branch_t       chan_mem [`CAP_DEPTH];
  logic          last_mem [`CAP_DEPTH];
  logic [AW-1:0] wr_ptr, rd_ptr;
  credit_t       count;       // occupied slots
  logic          pop;

  assign out_valid = (count != '0);
  assign pop       = out_valid && out_ready;
  assign out_data  = data_mem[rd_ptr];  // head slot straight out
  assign out_chan  = chan_mem[rd_ptr];
  assign out_last  = last_mem[rd_ptr];

  // payload, written every valid result
  always_ff @(posedge clkb) begin
    if (res_valid) begin
      data_mem[wr_ptr] <= res_data;
      chan_mem[wr_ptr] <= res_chan;
      last_mem[wr_ptr] <= res_last;
    end
  end

  always_ff @(posedge clkb) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end else begin
      if (res_valid) wr_ptr <= (wr_ptr == AW'(`CAP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == AW'(`CAP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (res_valid && !pop) count <= count + 1'b1;
      else if (pop && !res_valid) count <= count - 1'b1;
      credit_ret <= pop;  // slot freed, hand one credit back
    end
  end

  // credit loop keeps writes away from a full buffer
  a_no_capture_overflow: assert property (
    @(posedge clkb) disable iff (!rst_n)
    res_valid |-> (count < credit_t'(`CAP_DEPTH)) || pop
  );

endmodule

// File: design/ospfb_top.sv
`timescale 1ns/10ps

module ospfb_top (
  input  logic               clka,
  input  logic               clkb,
  input  logic               rst_n,
  input  logic               en,
  input  logic               out_ready,
  output logic               out_valid,
  output ospfb_pkg::acc_t    out_data,
  output ospfb_pkg::branch_t out_chan,
  output logic               out_last,
  output logic               event_frame_started,
  output ospfb_pkg::level_t  fifo_level
);

  import ospfb_pkg::*;

  sample_t wr_data, rd_data, push_data, rd_sample;
  logic    wr_en, full, rd_en, empty, push;
  age_t    rd_age;
  logic    res_valid, res_last, credit_ret;
  acc_t    res_data;
  branch_t res_chan;

  // counter source, clka
  sample_counter u_src (
    .clka(clka), .rst_n(rst_n), .en(en), .full(full),
    .wr_data(wr_data), .wr_en(wr_en)
  );

  cdc_fifo u_fifo (
    .clka(clka), .clkb(clkb), .rst_n(rst_n),
    .wr_data(wr_data), .wr_en(wr_en), .full(full),
    .rd_data(rd_data), .rd_en(rd_en), .empty(empty), .rd_level(fifo_level)
  );

  pfb_delay_line u_dline (
    .clkb(clkb), .rst_n(rst_n), .push(push), .push_data(push_data),
    .rd_age(rd_age), .rd_sample(rd_sample)
  );

  pfb_channelizer u_chan (
    .clkb(clkb), .rst_n(rst_n), .en(en),
    .rd_data(rd_data), .empty(empty), .rd_en(rd_en),
    .push(push), .push_data(push_data), .rd_age(rd_age), .rd_sample(rd_sample),
    .credit_ret(credit_ret), .res_valid(res_valid), .res_data(res_data),
    .res_chan(res_chan), .res_last(res_last),
    .event_frame_started(event_frame_started)
  );

  // capture buffer, drained by out_ready
  frame_capture u_cap (
    .clkb(clkb), .rst_n(rst_n), .res_valid(res_valid), .res_data(res_data),
    .res_chan(res_chan), .res_last(res_last), .out_valid(out_valid),
    .out_data(out_data), .out_chan(out_chan), .out_last(out_last),
    .out_ready(out_ready), .credit_ret(credit_ret)
  );

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/10ps

// free running clock, first rising edge at PHASE_NS
module clock_gen #(
  parameter real PHASE_NS  = 0.0,
  parameter real PERIOD_NS = 10.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    #(PHASE_NS);  // offset between the two domains
    forever begin
      clk = 1'b1;
      #(PERIOD_NS / 2.0);
      clk = 1'b0;
      #(PERIOD_NS / 2.0);
    end
  end

endmodule

// File: bench/ospfb_tb.sv
`timescale 1ns/10ps
`include "ospfb_macros.svh"

module ospfb_tb;

  import ospfb_pkg::*;

  localparam int NUM_FRAMES  = 40;
  localparam int WIN         = `PFB_TAPS * `FFT_LEN;  // samples in one filter window
  localparam int TIMEOUT_CYC = NUM_FRAMES * `FFT_LEN * (`PFB_TAPS + 2) * 4 + 500;
  localparam int MAX_AHEAD   = `CAP_DEPTH / `FFT_LEN + 1;  // frames buffered plus one in flight

  logic    clka, clkb;
  logic    rst_n, en, out_ready;
  logic    out_valid, out_last, event_frame_started;
  acc_t    out_data;
  branch_t out_chan;
  level_t  fifo_level;

  int err_cnt;
  int pos;          // next expected output position
  int done_frames;  // frames fully popped, also the model frame number
  int started;      // frame start pulses seen
  int cycles;       // clkb cycles since reset release

  clock_gen #(.PHASE_NS(0.0)) u_clka (.clk(clka));
  clock_gen #(.PHASE_NS(3.0)) u_clkb (.clk(clkb));  // clkb lags clka by 3 ns

  ospfb_top DUT (
    .clka(clka), .clkb(clkb), .rst_n(rst_n), .en(en), .out_ready(out_ready),
    .out_valid(out_valid), .out_data(out_data), .out_chan(out_chan),
    .out_last(out_last), .event_frame_started(event_frame_started),
    .fifo_level(fifo_level)
  );

  // reference branch sum for frame m, branch b
  function automatic acc_t branch_sum(input int m, input int b);
    int t;
    int p;
    int idx;
    int samp;
    int sum;
    t   = WIN - 1 + m * `DEC_FAC;  // newest sample of the frame
    sum = 0;
    for (p = 0; p < `PFB_TAPS; p++) begin
      idx  = p * `FFT_LEN + b;
      samp = (t - idx) % (1 << `SAMP_W);  // counter value, wraps at 2^SAMP_W
      sum  = sum + samp * int'(coeff(idx));
    end
    return acc_t'(sum);
  endfunction

  task automatic stop_run(input string why);
    err_cnt++;
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input acc_t exp, input acc_t act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      stop_run("output word mismatch");
    end
  endtask

  task automatic check_chan(input string name, input branch_t exp, input branch_t act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      stop_run("channel index mismatch");
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_run("frame end flag mismatch");
    end
  endtask

  // occasional source pauses, clka side
  task automatic drive_en();
    forever begin
      @(posedge clka);
      #1;
      if ($urandom_range(63) == 0) begin
        en = 1'b0;
        repeat ($urandom_range(30, 1)) @(posedge clka);
        #1;
        en = 1'b1;
      end
    end
  endtask

  // drain side, mostly ready with rare long stalls
  task automatic drive_ready();
    forever begin
      @(posedge clkb);
      #1;
      if ($urandom_range(199) == 0) begin
        out_ready = 1'b0;  // long stall, fills capture and runs credits out
        repeat ($urandom_range(120, 20)) @(posedge clkb);
        #1;
      end
      out_ready = ($urandom_range(3) != 0);
    end
  endtask

  // one clkb cycle of checking, sampled mid cycle
  task automatic monitor_cycle();
    int   exp_b;
    acc_t exp_v;
    int   ahead;
    cycles++;
    if (cycles > TIMEOUT_CYC) begin
      stop_run($sformatf("timeout: %0d of %0d frames received after %0d clkb cycles",
                         done_frames, NUM_FRAMES, cycles));
    end
    if (fifo_level > level_t'(`FIFO_DEPTH)) begin
      stop_run($sformatf("fifo level %0d is above the fifo depth", fifo_level));
    end
    if (event_frame_started) started++;
    if (out_valid && out_ready) begin  // pop on the coming edge
      // rotated branch, frame 0 has zero phase so position equals branch
      exp_b = (pos + done_frames * `DEC_FAC) % `FFT_LEN;
      exp_v = branch_sum(done_frames, exp_b);
      check_chan("out_chan", branch_t'(pos), out_chan);
      check_last("out_last", pos == `FFT_LEN - 1, out_last);
      check_data("out_data", exp_v, out_data);
      if (pos == `FFT_LEN - 1) begin
        pos = 0;
        done_frames++;
      end else begin
        pos++;
      end
    end
    ahead = started - done_frames;
    if (ahead < 0) begin
      stop_run("a frame reached the output without a frame start event");
    end
    if (ahead > MAX_AHEAD) begin
      stop_run($sformatf("%0d frames started but not yet drained, limit is %0d",
                         ahead, MAX_AHEAD));
    end
  endtask

  initial begin
    void'($urandom(34625));  // one seed for the whole run
    rst_n       = 1'b0;
    en          = 1'b0;
    out_ready   = 1'b0;
    err_cnt     = 0;
    pos         = 0;
    done_frames = 0;
    started     = 0;
    cycles      = 0;
    repeat (16) @(posedge clkb);  // clkb lags, clka has seen its 16 edges by now
    @(posedge clka);
    #1;
    rst_n = 1'b1;
    en    = 1'b1;
    fork
      drive_en();
      drive_ready();
    join_none
    while (done_frames < NUM_FRAMES) begin
      @(negedge clkb);  // outputs settled, ready already driven
      monitor_cycle();
    end
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "errors were reported");
    end
  end

endmodule

// File: filelist.f
+incdir+design
design/ospfb_pkg.sv
design/sample_counter.sv
design/cdc_fifo.sv
design/pfb_delay_line.sv
design/pfb_channelizer.sv
design/frame_capture.sv
design/ospfb_top.sv
bench/clock_gen.sv
bench/ospfb_tb.sv
